// File: project.f
+incdir+rtl
rtl/sp_pkg.sv
rtl/sp_bus_decode.sv
rtl/int_ctrl.sv
rtl/system_timer.sv
rtl/sp_read_return.sv
rtl/system_peripheral.sv
tb/sp_chk.sv
tb/sp_tb.sv

// File: rtl/int_ctrl.sv
/* interrupt controller: external pending and enable registers,
   claim code and the software interrupt register */
module int_ctrl
  import sp_pkg::*;
(
  input  logic         hb_clk,
  input  logic         rst_sync,
  input  logic         ren,
  input  logic         wen,
  input  sp_offset_t   roff,
  input  sp_offset_t   woff,
  input  sp_word_t     wdata,
  input  sp_irq_vec_t  irq_source,
  output sp_word_t     rdata,
  output logic         mextern_int,
  output sp_int_code_t custom_int_code,
  output logic         msoftware_int
);

  localparam int IRQ_N = $bits(sp_irq_vec_t);

  sp_irq_vec_t  pending;
  sp_irq_vec_t  enable;
  sp_irq_vec_t  clr_mask;
  logic [15:0]  soft_reg;
  sp_int_code_t claim_code;

  // write one to clear on offset 0
  assign clr_mask = (wen && woff == 2'd0) ? wdata[IRQ_N-1:0] : '0;

  // a new request wins over a clear in the same cycle
  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | (irq_source & enable);
    end
  end

  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      enable   <= '0;
      soft_reg <= '0;
    end else if (wen) begin
      case (woff)
        2'd1: enable <= wdata[IRQ_N-1:0];
        2'd2: soft_reg <= wdata[15:0];
        default: ;
      endcase
    end
  end

  // lowest pending index wins
  always_comb begin
    claim_code = '0;
    for (int i = IRQ_N - 1; i >= 0; i--) begin
      if (pending[i]) begin
        claim_code = sp_int_code_t'(i + 1);
      end
    end
  end

  assign mextern_int     = |pending;
  assign custom_int_code = claim_code;
  // bit 15 raises the request, low bits hold the cause
  assign msoftware_int   = soft_reg[15];

  // read word captured on the strobe edge
  always_ff @(posedge hb_clk) begin
    if (ren) begin
      case (roff)
        2'd0: rdata <= sp_word_t'(pending);
        2'd1: rdata <= sp_word_t'(enable);
        2'd2: rdata <= sp_word_t'(soft_reg);
        default: rdata <= {1'b0, claim_code};
      endcase
    end
  end

endmodule

// File: rtl/sp_bus_decode.sv
/* bus address decode into device id and offset, with gated
   per-device read and write strobes */
`include "sp_defines.svh"

module sp_bus_decode
  import sp_pkg::*;
(
  input  logic        ren,
  input  logic        wen,
  input  logic [31:0] raddr,
  input  logic [31:0] waddr,
  input  logic        read_finish,
  output logic        int_ren,
  output logic        int_wen,
  output logic        tmr_ren,
  output logic        tmr_wen,
  output sp_dev_sel_t rsel,
  output sp_offset_t  roff,
  output sp_offset_t  woff
);

  // word address inside the peripheral window
  logic [`SP_ADDR_LEN-1:0] raddr_word;
  logic [`SP_ADDR_LEN-1:0] waddr_word;
  logic [`SP_ID_LEN-1:0]   rid;
  logic [`SP_ID_LEN-1:0]   wid;
  sp_dev_sel_t             wsel;
  logic                    read_go;

  assign raddr_word = raddr[`SP_ADDR_LEN+1:2];
  assign waddr_word = waddr[`SP_ADDR_LEN+1:2];

  // split into id and offset
  assign roff = raddr_word[`SP_OFFSET_LEN-1:0];
  assign woff = waddr_word[`SP_OFFSET_LEN-1:0];
  assign rid  = raddr_word[`SP_ADDR_LEN-1:`SP_OFFSET_LEN];
  assign wid  = waddr_word[`SP_ADDR_LEN-1:`SP_OFFSET_LEN];

  // id match, unmapped ids leave both bits low
  always_comb begin
    rsel = '0;
    wsel = '0;
    rsel[SEL_INT] = (rid == `SP_ID_LEN'(`SP_ID_INT));
    rsel[SEL_TMR] = (rid == `SP_ID_LEN'(`SP_ID_TIMER));
    wsel[SEL_INT] = (wid == `SP_ID_LEN'(`SP_ID_INT));
    wsel[SEL_TMR] = (wid == `SP_ID_LEN'(`SP_ID_TIMER));
  end

  // only the first ren cycle of a read reaches a device
  assign read_go = ren && !read_finish;

  assign int_ren = read_go && rsel[SEL_INT];
  assign tmr_ren = read_go && rsel[SEL_TMR];
  assign int_wen = wen && wsel[SEL_INT];
  assign tmr_wen = wen && wsel[SEL_TMR];

endmodule

// File: rtl/sp_defines.svh
/* address field widths, device IDs and interrupt source count
   for the system peripheral block */
`ifndef SP_DEFINES_SVH
`define SP_DEFINES_SVH

// word address bits decoded, byte address bits 6 down to 2
`define SP_ADDR_LEN 5

// offset bits inside one device, four registers each
`define SP_OFFSET_LEN 2

// device id bits above the offset
`define SP_ID_LEN 3

// device ids
`define SP_ID_INT 1
`define SP_ID_TIMER 2

// external interrupt sources
`define SP_EXT_INT_NUM 13

`endif

// File: rtl/sp_pkg.sv
/* shared word, offset, device select and interrupt types */
`include "sp_defines.svh"

package sp_pkg;

  // one bus data word
  typedef logic [31:0] sp_word_t;

  // register offset inside a device
  typedef logic [`SP_OFFSET_LEN-1:0] sp_offset_t;

  // one-hot device select
  typedef logic [1:0] sp_dev_sel_t;

  // bit positions in sp_dev_sel_t
  localparam int SEL_INT = 0;
  localparam int SEL_TMR = 1;

  // external interrupt sources
  typedef logic [`SP_EXT_INT_NUM-1:0] sp_irq_vec_t;

  // claim code, lowest pending source plus one
  typedef logic [30:0] sp_int_code_t;

endpackage

// File: rtl/sp_read_return.sv
/* read return: read_finish sequencing and read data select */
module sp_read_return
  import sp_pkg::*;
(
  input  logic        hb_clk,
  input  logic        rst_sync,
  input  logic        ren,
  input  sp_dev_sel_t rsel,
  input  sp_word_t    int_rdata,
  input  sp_word_t    tmr_rdata,
  output logic        read_finish,
  output sp_word_t    rdata
);

  // one cycle high after the first ren cycle, then low again
  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      read_finish <= 1'b0;
    end else if (read_finish) begin
      read_finish <= 1'b0;
    end else if (ren) begin
      read_finish <= 1'b1;
    end
  end

  // master holds raddr, so rsel still names the device
  always_comb begin
    if (rsel[SEL_INT]) begin
      rdata = int_rdata;
    end else if (rsel[SEL_TMR]) begin
      rdata = tmr_rdata;
    end else begin
      rdata = '0;
    end
  end

endmodule

// File: rtl/system_peripheral.sv
/* system peripheral top: bus decode, interrupt controller,
   machine timer and read return */
module system_peripheral
  import sp_pkg::*;
(
  input  logic         hb_clk,
  input  logic         rst_sync,
  input  logic         ren,
  input  logic         wen,
  input  logic [31:0]  raddr,
  input  logic [31:0]  waddr,
  input  sp_word_t     wdata,
  output logic         read_finish,
  output sp_word_t     rdata,
  input  sp_irq_vec_t  irq_source,
  input  logic         timer_tick,
  output logic         mextern_int,
  output sp_int_code_t custom_int_code,
  output logic         msoftware_int,
  output logic         mtimer_int
);

  logic        int_ren;
  logic        int_wen;
  logic        tmr_ren;
  logic        tmr_wen;
  sp_dev_sel_t rsel;
  sp_offset_t  roff;
  sp_offset_t  woff;
  sp_word_t    int_rdata;
  sp_word_t    tmr_rdata;

  sp_bus_decode u_decode (
    .ren         (ren),
    .wen         (wen),
    .raddr       (raddr),
    .waddr       (waddr),
    .read_finish (read_finish),
    .int_ren     (int_ren),
    .int_wen     (int_wen),
    .tmr_ren     (tmr_ren),
    .tmr_wen     (tmr_wen),
    .rsel        (rsel),
    .roff        (roff),
    .woff        (woff)
  );

  int_ctrl u_int_ctrl (
    .hb_clk          (hb_clk),
    .rst_sync        (rst_sync),
    .ren             (int_ren),
    .wen             (int_wen),
    .roff            (roff),
    .woff            (woff),
    .wdata           (wdata),
    .irq_source      (irq_source),
    .rdata           (int_rdata),
    .mextern_int     (mextern_int),
    .custom_int_code (custom_int_code),
    .msoftware_int   (msoftware_int)
  );

  system_timer u_timer (
    .hb_clk     (hb_clk),
    .rst_sync   (rst_sync),
    .ren        (tmr_ren),
    .wen        (tmr_wen),
    .roff       (roff),
    .woff       (woff),
    .wdata      (wdata),
    .timer_tick (timer_tick),
    .rdata      (tmr_rdata),
    .mtimer_int (mtimer_int)
  );

  sp_read_return u_read_return (
    .hb_clk      (hb_clk),
    .rst_sync    (rst_sync),
    .ren         (ren),
    .rsel        (rsel),
    .int_rdata   (int_rdata),
    .tmr_rdata   (tmr_rdata),
    .read_finish (read_finish),
    .rdata       (rdata)
  );

endmodule

// File: rtl/system_timer.sv
/* machine timer: 64-bit mtime and mtimecmp with the
   timer interrupt compare */
module system_timer
  import sp_pkg::*;
(
  input  logic       hb_clk,
  input  logic       rst_sync,
  input  logic       ren,
  input  logic       wen,
  input  sp_offset_t roff,
  input  sp_offset_t woff,
  input  sp_word_t   wdata,
  input  logic       timer_tick,
  output sp_word_t   rdata,
  output logic       mtimer_int
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        mtime_wr;

  // offsets 0 and 1 address mtime
  assign mtime_wr = wen && (woff == 2'd0 || woff == 2'd1);

  // a bus write to mtime wins over a tick
  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      mtime <= '0;
    end else if (mtime_wr) begin
      if (woff == 2'd0) begin
        mtime[31:0] <= wdata;
      end else begin
        mtime[63:32] <= wdata;
      end
    end else if (timer_tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  // compare value starts at the top so no interrupt fires early
  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      mtimecmp <= '1;
    end else if (wen) begin
      case (woff)
        2'd2: mtimecmp[31:0] <= wdata;
        2'd3: mtimecmp[63:32] <= wdata;
        default: ;
      endcase
    end
  end

  assign mtimer_int = (mtime >= mtimecmp);

  // read word captured on the strobe edge
  always_ff @(posedge hb_clk) begin
    if (ren) begin
      case (roff)
        2'd0: rdata <= mtime[31:0];
        2'd1: rdata <= mtime[63:32];
        2'd2: rdata <= mtimecmp[31:0];
        default: rdata <= mtimecmp[63:32];
      endcase
    end
  end

endmodule

// File: tb/sp_chk.sv
/* bound assertions for read_finish width, the timer interrupt hold
   and single device read strobes */
module sp_chk (
  input logic        hb_clk,
  input logic        rst_sync,
  input logic        read_finish,
  input logic        int_ren,
  input logic        tmr_ren,
  input logic        tmr_wen,
  input logic        mtimer_int,
  input logic [63:0] mtime
);

  // one finish pulse per read
  a_finish_one_cycle: assert property (
    @(posedge hb_clk) disable iff (rst_sync) read_finish |=> !read_finish
  ) else $error("read_finish high in two consecutive cycles");

  // interrupt stays up until software writes the timer
  a_timer_int_hold: assert property (
    @(posedge hb_clk) disable iff (rst_sync)
      mtimer_int && !tmr_wen && mtime != '1 |=> mtimer_int
  ) else $error("mtimer_int dropped without a timer register write");

  // a read reaches its device in one cycle only
  a_one_read_strobe: assert property (
    @(posedge hb_clk) disable iff (rst_sync)
      (int_ren || tmr_ren) |=> !(int_ren || tmr_ren)
  ) else $error("device read strobe high in two consecutive cycles");

endmodule

bind system_peripheral sp_chk u_chk (
  .hb_clk      (hb_clk),
  .rst_sync    (rst_sync),
  .read_finish (read_finish),
  .int_ren     (int_ren),
  .tmr_ren     (tmr_ren),
  .tmr_wen     (tmr_wen),
  .mtimer_int  (mtimer_int),
  .mtime       (u_timer.mtime)
);

// File: tb/sp_tb.sv
/* testbench with clock, reset, DUT, bus and check tasks,
   and directed tests for the system peripheral */
`include "sp_defines.svh"

module sp_tb
  import sp_pkg::*;
();

  logic         hb_clk, rst_sync, ren, wen, timer_tick;
  logic [31:0]  raddr, waddr;
  sp_word_t     wdata, rdata;
  sp_irq_vec_t  irq_source;
  logic         read_finish, mextern_int, msoftware_int, mtimer_int;
  sp_int_code_t custom_int_code;
  int           errors = 0;
  logic [31:0]  rng_state = 32'd93471;

  system_peripheral DUT (.*);

  initial begin
    hb_clk = 1'b0;
    forever #10 hb_clk = ~hb_clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [31:0] reg_addr(int id, int off);
    return 32'((id << `SP_OFFSET_LEN) + off) << 2;
  endfunction

  // first set bit from the bottom, plus one
  function automatic sp_int_code_t lowest_code(sp_irq_vec_t p);
    for (int i = 0; i < `SP_EXT_INT_NUM; i++) begin
      if (p[i]) begin
        return sp_int_code_t'(i + 1);
      end
    end
    return '0;
  endfunction

  task automatic check_word(string name, sp_word_t exp, sp_word_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_code(string name, sp_int_code_t exp, sp_int_code_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic bus_write(logic [31:0] addr, sp_word_t data);
    @(negedge hb_clk);
    wen   = 1'b1;
    waddr = addr;
    wdata = data;
    @(negedge hb_clk);
    wen = 1'b0;
  endtask

  task automatic bus_read(string name, logic [31:0] addr, output sp_word_t data);
    int cycles;
    cycles = 0;
    @(negedge hb_clk);
    ren   = 1'b1;
    raddr = addr;
    do begin
      @(negedge hb_clk);
      cycles++;
    end while (!read_finish && cycles < 20);
    if (!read_finish) begin
      $display("%s: read_finish did not arrive within 20 cycles", name);
      errors++;
    end else if (cycles != 1) begin
      $display("FAIL %s: expected read_finish after 1 cycle, actual %0d", name, cycles);
      errors++;
    end
    data = rdata;
    ren  = 1'b0;
  endtask

  task automatic read_check(string name, logic [31:0] addr, sp_word_t exp);
    sp_word_t d;
    bus_read(name, addr, d);
    check_word(name, exp, d);
  endtask

  task automatic tick(int n);
    @(negedge hb_clk);
    timer_tick = 1'b1;
    repeat (n) @(negedge hb_clk);
    timer_tick = 1'b0;
  endtask

  task automatic test_reset();
    check_bit("reset read_finish", 1'b0, read_finish);
    check_bit("reset mextern_int", 1'b0, mextern_int);
    check_bit("reset msoftware_int", 1'b0, msoftware_int);
    check_bit("reset mtimer_int", 1'b0, mtimer_int);
    check_code("reset custom_int_code", '0, custom_int_code);
    read_check("reset mtimecmp lo", reg_addr(`SP_ID_TIMER, 2), '1);
    read_check("reset mtimecmp hi", reg_addr(`SP_ID_TIMER, 3), '1);
  endtask

  task automatic test_read_decode();
    sp_word_t w;
    w = next_rand();
    read_check("unmapped id 5", reg_addr(5, 0), '0);
    bus_write(reg_addr(`SP_ID_INT, 2), w);
    read_check("software reg", reg_addr(`SP_ID_INT, 2), {16'h0, w[15:0]});
    check_bit("msoftware_int", w[15], msoftware_int);
  endtask

  task automatic test_ext_irq();
    sp_irq_vec_t en, src, exp;
    // bit 8 forced in both so something ends up pending
    en  = sp_irq_vec_t'(next_rand()) | 13'h0100;
    src = sp_irq_vec_t'(next_rand()) | 13'h0100;
    exp = src & en;
    bus_write(reg_addr(`SP_ID_INT, 1), sp_word_t'(en));
    @(negedge hb_clk);
    irq_source = src;
    @(negedge hb_clk);
    irq_source = '0;
    check_bit("irq mextern_int", 1'b1, mextern_int);
    check_code("irq custom_int_code", lowest_code(exp), custom_int_code);
    read_check("irq pending", reg_addr(`SP_ID_INT, 0), sp_word_t'(exp));
    read_check("irq claim read", reg_addr(`SP_ID_INT, 3), sp_word_t'(lowest_code(exp)));
    bus_write(reg_addr(`SP_ID_INT, 0), sp_word_t'(exp));
    check_bit("irq cleared", 1'b0, mextern_int);
    check_code("irq cleared code", '0, custom_int_code);
  endtask

  task automatic test_timer_count();
    logic [63:0] exp;
    int          n;
    exp = {next_rand(), next_rand()};
    n   = 3 + int'(next_rand() % 6);
    bus_write(reg_addr(`SP_ID_TIMER, 0), exp[31:0]);
    bus_write(reg_addr(`SP_ID_TIMER, 1), exp[63:32]);
    tick(n);
    exp = exp + 64'(n);
    read_check("mtime lo", reg_addr(`SP_ID_TIMER, 0), exp[31:0]);
    read_check("mtime hi", reg_addr(`SP_ID_TIMER, 1), exp[63:32]);
    // carry out of the low word
    bus_write(reg_addr(`SP_ID_TIMER, 0), '1);
    tick(1);
    exp = {exp[63:32] + 32'd1, 32'd0};
    read_check("mtime carry lo", reg_addr(`SP_ID_TIMER, 0), exp[31:0]);
    read_check("mtime carry hi", reg_addr(`SP_ID_TIMER, 1), exp[63:32]);
  endtask

  task automatic test_timer_irq();
    sp_word_t base;
    base = next_rand() & 32'h0fff_ffff;
    bus_write(reg_addr(`SP_ID_TIMER, 0), base);
    bus_write(reg_addr(`SP_ID_TIMER, 1), '0);
    bus_write(reg_addr(`SP_ID_TIMER, 2), base + 32'd3);
    bus_write(reg_addr(`SP_ID_TIMER, 3), '0);
    check_bit("timer below compare", 1'b0, mtimer_int);
    tick(3);
    check_bit("timer at compare", 1'b1, mtimer_int);
    bus_write(reg_addr(`SP_ID_TIMER, 2), base + 32'd100);
    check_bit("timer compare raised", 1'b0, mtimer_int);
  endtask

  initial begin
    rst_sync   = 1'b1;
    ren        = 1'b0;
    wen        = 1'b0;
    raddr      = '0;
    waddr      = '0;
    wdata      = '0;
    irq_source = '0;
    timer_tick = 1'b0;
    repeat (10) @(posedge hb_clk);
    @(negedge hb_clk);
    rst_sync = 1'b0;
    test_reset();
    test_read_decode();
    test_ext_irq();
    test_timer_count();
    test_timer_irq();
    $display("errors counted: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
